// ==== Makefile ====
# Verilator build and run of the prefetch buffer testbench

VERILATOR ?= verilator
TOP       ?= tb_prefetch_buffer
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SIM  := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' src.f)
HDRS := $(wildcard rtl/*.svh)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(HDRS) src.f
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f src.f

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

// ==== rtl/instr_aligner.sv ====
////////////////////////////////////////
// core side of the prefetch buffer
// cuts 16 and 32 bit instructions out of fetched lines
////////////////////////////////////////

`include "prefetch_params.svh"

module instr_aligner import prefetch_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,

  input  logic        branch_i,
  input  addr_t       branch_addr_i,

  input  logic        ready_i,
  output logic        valid_o,
  output instr_out_t  instr_o,

  // line fetcher
  output fetch_req_t  fetch_req_o,
  input  logic        fetch_gnt_i,
  input  logic        fetch_line_valid_i,
  input  fetch_line_t fetch_line_i
);

  align_state_e state_q, state_n;

  addr_t addr_q, addr_n;
  addr_t addr_adv;
  addr_t seq_addr;
  addr_t req_addr;
  word_t last_q;
  word_t cur_word;
  word_t w3;
  word_t instr;

  logic [1:0]            cur_idx;
  logic [1:0]            nxt_idx;
  logic [`PF_HALF_W-1:0] next_half;

  fetch_cmd_e cmd;
  logic       use_last;
  logic       is_compressed;
  logic       adv_wrap;
  logic       is_cross;
  logic       next_cross;
  logic       valid;
  logic       save_last;
  logic       held_step;
  logic       cross_step;

  ////////////////////////////////////////
  // instruction extraction
  ////////////////////////////////////////

  // word 3 comes from the saved copy once the next line is on its way
  assign use_last = (state_q == ALIGN_VALID_GRANTED) || (state_q == ALIGN_VALID_CROSS) ||
                    (state_q == ALIGN_NOT_VALID_CROSS) ||
                    (state_q == ALIGN_NOT_VALID_CROSS_GRANTED);

  assign cur_idx   = addr_q[3:2];
  // wraps to word 0 of the next line for a crossword
  assign nxt_idx   = cur_idx + 2'd1;
  assign cur_word  = use_last ? last_q : fetch_line_i.data[cur_idx];
  assign w3        = use_last ? last_q : fetch_line_i.data[3];
  assign next_half = fetch_line_i.data[nxt_idx][`PF_HALF_W-1:0];

  assign instr = addr_q[1] ? {next_half, cur_word[`PF_WORD_W-1:`PF_HALF_W]} : cur_word;

  assign is_compressed = instr[1:0] != 2'b11;
  assign addr_adv      = addr_q + (is_compressed ? addr_t'(2) : addr_t'(4));
  assign adv_wrap      = addr_adv[`PF_ADDR_W-1:`PF_LINE_OFS_W] !=
                         addr_q[`PF_ADDR_W-1:`PF_LINE_OFS_W];

  // 32 bit instruction in the last halfword of the line
  assign is_cross   = (addr_q[3:1] == 3'b111) && (w3[17:16] == 2'b11);
  assign next_cross = (addr_adv[3:1] == 3'b111) && (w3[17:16] == 2'b11);

  assign seq_addr = fetch_line_i.addr + (addr_t'(1) << `PF_LINE_OFS_W);

  ////////////////////////////////////////
  // fsm
  ////////////////////////////////////////

  always_comb begin
    state_n    = state_q;
    addr_n     = addr_q;
    valid      = 1'b0;
    save_last  = 1'b0;
    held_step  = 1'b0;
    cross_step = 1'b0;
    cmd        = FETCH_NONE;
    req_addr   = seq_addr;

    case (state_q)
      ALIGN_IDLE: ;

      ALIGN_BRANCHED, ALIGN_NOT_VALID_GRANTED: begin
        if (fetch_line_valid_i) begin
          if (is_cross) begin
            save_last = 1'b1;
            cmd       = FETCH_SEQ;
            state_n   = fetch_gnt_i ? ALIGN_NOT_VALID_CROSS_GRANTED : ALIGN_NOT_VALID_CROSS;
          end else begin
            held_step = 1'b1;
          end
        end
      end

      ALIGN_NOT_VALID: begin
        cmd = FETCH_SEQ;
        if (fetch_gnt_i)
          state_n = ALIGN_NOT_VALID_GRANTED;
      end

      ALIGN_NOT_VALID_CROSS: begin
        cmd = FETCH_SEQ;
        if (fetch_gnt_i)
          state_n = ALIGN_NOT_VALID_CROSS_GRANTED;
      end

      ALIGN_NOT_VALID_CROSS_GRANTED: cross_step = fetch_line_valid_i;

      ALIGN_VALID: held_step = 1'b1;

      ALIGN_VALID_GRANTED: begin
        valid = 1'b1;
        if (ready_i) begin
          addr_n = addr_adv;
          if (adv_wrap)
            state_n = fetch_line_valid_i ? ALIGN_VALID : ALIGN_NOT_VALID_GRANTED;
          else if (fetch_line_valid_i)
            state_n = ALIGN_VALID_CROSS;
          else if (next_cross)
            state_n = ALIGN_NOT_VALID_CROSS_GRANTED;
        end else if (fetch_line_valid_i) begin
          state_n = ALIGN_VALID_CROSS;
        end
      end

      ALIGN_VALID_CROSS: cross_step = 1'b1;

      default: state_n = ALIGN_IDLE;
    endcase

    // instruction inside the current line, prefetch while in word 3
    if (held_step) begin
      valid = 1'b1;
      if (cur_idx == 2'b11)
        cmd = FETCH_SEQ;
      state_n = ALIGN_VALID;
      if (ready_i) begin
        addr_n = addr_adv;
        if (adv_wrap) begin
          state_n = fetch_gnt_i ? ALIGN_NOT_VALID_GRANTED : ALIGN_NOT_VALID;
        end else if (next_cross) begin
          save_last = 1'b1;
          state_n   = fetch_gnt_i ? ALIGN_NOT_VALID_CROSS_GRANTED : ALIGN_NOT_VALID_CROSS;
        end else if (fetch_gnt_i) begin
          save_last = 1'b1;
          state_n   = ALIGN_VALID_GRANTED;
        end
      end else if (fetch_gnt_i) begin
        save_last = 1'b1;
        state_n   = ALIGN_VALID_GRANTED;
      end
    end

    // saved word 3 plus the next line held by the fetcher
    if (cross_step) begin
      valid   = 1'b1;
      state_n = ALIGN_VALID_CROSS;
      if (ready_i) begin
        addr_n = addr_adv;
        if (adv_wrap)
          state_n = ALIGN_VALID;
      end
    end

    // branches win over everything
    if (branch_i) begin
      valid     = 1'b0;
      save_last = 1'b0;
      cmd       = FETCH_BRANCH;
      req_addr  = branch_addr_i;
      addr_n    = branch_addr_i;
      state_n   = ALIGN_BRANCHED;
    end
  end

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ALIGN_IDLE;
      addr_q  <= '0;
    end else begin
      state_q <= state_n;
      addr_q  <= addr_n;
    end
  end

  always_ff @(posedge clk) begin
    if (save_last)
      last_q <= w3;
  end

  assign fetch_req_o = '{cmd: cmd, addr: req_addr};
  assign valid_o     = valid;
  assign instr_o     = '{instr: instr, addr: addr_q};

endmodule

// ==== rtl/line_fetcher.sv ====
////////////////////////////////////////
// memory side of the prefetch buffer
// issues line requests on command and holds the last fetched line
////////////////////////////////////////

`include "prefetch_params.svh"

module line_fetcher import prefetch_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,

  // aligner side
  input  fetch_req_t  fetch_req_i,
  output logic        fetch_gnt_o,
  output logic        fetch_line_valid_o,
  output fetch_line_t fetch_line_o,

  // instruction memory
  output logic        instr_req_o,
  output mem_req_t    instr_addr_o,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  line_t       instr_rdata_i,

  output logic        busy_o
);

  fetch_state_e state_q, state_n;

  addr_t addr_q;
  addr_t req_addr;
  addr_t line_addr_q;
  line_t line_q;
  logic  addr_load;
  logic  new_cmd;
  logic  is_branch;
  logic  line_arrive;

  assign new_cmd     = fetch_req_i.cmd != FETCH_NONE;
  assign is_branch   = fetch_req_i.cmd == FETCH_BRANCH;
  assign line_arrive = (state_q == FETCH_WAIT_RVALID) && instr_rvalid_i;

  ////////////////////////////////////////
  // fsm
  ////////////////////////////////////////

  always_comb begin
    state_n     = state_q;
    instr_req_o = 1'b0;
    req_addr    = fetch_req_i.addr;
    addr_load   = 1'b0;

    case (state_q)
      FETCH_IDLE, FETCH_LINE_VALID: begin
        if (new_cmd) begin
          instr_req_o = 1'b1;
          addr_load   = 1'b1;
          state_n     = instr_gnt_i ? FETCH_WAIT_RVALID : FETCH_WAIT_GNT;
        end
      end

      FETCH_WAIT_GNT: begin
        // keep asking, a branch may swap the address
        instr_req_o = 1'b1;
        if (is_branch)
          addr_load = 1'b1;
        else
          req_addr = addr_q;
        if (instr_gnt_i)
          state_n = FETCH_WAIT_RVALID;
      end

      FETCH_WAIT_RVALID: begin
        if (instr_rvalid_i) begin
          if (new_cmd) begin
            instr_req_o = 1'b1;
            addr_load   = 1'b1;
            state_n     = instr_gnt_i ? FETCH_WAIT_RVALID : FETCH_WAIT_GNT;
          end else begin
            state_n = FETCH_LINE_VALID;
          end
        end else if (is_branch) begin
          // outstanding line is stale now
          addr_load = 1'b1;
          state_n   = FETCH_ABORTED;
        end
      end

      FETCH_ABORTED: begin
        if (is_branch)
          addr_load = 1'b1;
        else
          req_addr = addr_q;
        // drop the stale response and ask for the branch line
        if (instr_rvalid_i) begin
          instr_req_o = 1'b1;
          state_n     = instr_gnt_i ? FETCH_WAIT_RVALID : FETCH_WAIT_GNT;
        end
      end

      default: state_n = FETCH_IDLE;
    endcase
  end

  ////////////////////////////////////////
  // registers
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      state_q <= FETCH_IDLE;
    else
      state_q <= state_n;
  end

  always_ff @(posedge clk) begin
    if (addr_load)
      addr_q <= {req_addr[`PF_ADDR_W-1:`PF_LINE_OFS_W], {`PF_LINE_OFS_W{1'b0}}};
    if (line_arrive) begin
      line_q      <= instr_rdata_i;
      line_addr_q <= addr_q;
    end
  end

  // outputs
  assign instr_addr_o = '{line: req_addr[`PF_ADDR_W-1:`PF_LINE_OFS_W], offset: '0};
  assign fetch_gnt_o  = instr_req_o & instr_gnt_i;

  assign fetch_line_valid_o = line_arrive;
  // arriving data bypasses the line register
  assign fetch_line_o.data  = line_arrive ? instr_rdata_i : line_q;
  assign fetch_line_o.addr  = line_arrive ? addr_q : line_addr_q;

  assign busy_o = (state_q == FETCH_WAIT_GNT) || (state_q == FETCH_WAIT_RVALID) ||
                  (state_q == FETCH_ABORTED) || instr_req_o;

endmodule

// ==== rtl/prefetch_buffer.sv ====
////////////////////////////////////////
// instruction prefetch buffer top level
// joins the core side aligner to the memory side line fetcher
////////////////////////////////////////

module prefetch_buffer import prefetch_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,

  // core
  input  logic       branch_i,
  input  addr_t      branch_addr_i,
  input  logic       ready_i,
  output logic       valid_o,
  output instr_out_t instr_o,
  output logic       busy_o,

  // instruction memory
  output logic       instr_req_o,
  output mem_req_t   instr_addr_o,
  input  logic       instr_gnt_i,
  input  logic       instr_rvalid_i,
  input  line_t      instr_rdata_i
);

  fetch_req_t  fetch_req;
  logic        fetch_gnt;
  logic        fetch_line_valid;
  fetch_line_t fetch_line;

  instr_aligner instr_aligner_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .branch_i           (branch_i),
    .branch_addr_i      (branch_addr_i),
    .ready_i            (ready_i),
    .valid_o            (valid_o),
    .instr_o            (instr_o),
    .fetch_req_o        (fetch_req),
    .fetch_gnt_i        (fetch_gnt),
    .fetch_line_valid_i (fetch_line_valid),
    .fetch_line_i       (fetch_line)
  );

  line_fetcher line_fetcher_i (
    .clk                (clk),
    .rst_n              (rst_n),
    .fetch_req_i        (fetch_req),
    .fetch_gnt_o        (fetch_gnt),
    .fetch_line_valid_o (fetch_line_valid),
    .fetch_line_o       (fetch_line),
    .instr_req_o        (instr_req_o),
    .instr_addr_o       (instr_addr_o),
    .instr_gnt_i        (instr_gnt_i),
    .instr_rvalid_i     (instr_rvalid_i),
    .instr_rdata_i      (instr_rdata_i),
    .busy_o             (busy_o)
  );

endmodule

// ==== rtl/prefetch_params.svh ====
////////////////////////////////////////
// widths and memory line geometry of the prefetch buffer
// included ahead of the package and by the testbench
////////////////////////////////////////

`ifndef PREFETCH_PARAMS_SVH
`define PREFETCH_PARAMS_SVH

// byte address width
`define PF_ADDR_W 32

// full instruction word
`define PF_WORD_W 32

// compressed instruction
`define PF_HALF_W 16

// one memory line is four words
`define PF_LINE_WORDS 4

// byte offset bits inside a line
`define PF_LINE_OFS_W 4

`endif

// ==== rtl/prefetch_pkg.sv ====
////////////////////////////////////////
// shared data, struct and enum types of the prefetch buffer
////////////////////////////////////////

`include "prefetch_params.svh"

package prefetch_pkg;

  typedef logic [`PF_ADDR_W-1:0] addr_t;
  typedef logic [`PF_WORD_W-1:0] word_t;
  typedef word_t [`PF_LINE_WORDS-1:0] line_t;

  // line address towards memory, offset bits always zero
  typedef struct packed {
    logic [`PF_ADDR_W-`PF_LINE_OFS_W-1:0] line;
    logic [`PF_LINE_OFS_W-1:0]            offset;
  } mem_req_t;

  typedef enum logic [1:0] {
    FETCH_NONE,
    FETCH_SEQ,
    FETCH_BRANCH
  } fetch_cmd_e;

  typedef struct packed {
    fetch_cmd_e cmd;
    addr_t      addr;
  } fetch_req_t;

  typedef struct packed {
    line_t data;
    addr_t addr;
  } fetch_line_t;

  // compressed instructions use the low half of instr
  typedef struct packed {
    word_t instr;
    addr_t addr;
  } instr_out_t;

  typedef enum logic [2:0] {
    FETCH_IDLE,
    FETCH_WAIT_GNT,
    FETCH_WAIT_RVALID,
    FETCH_LINE_VALID,
    FETCH_ABORTED
  } fetch_state_e;

  typedef enum logic [3:0] {
    ALIGN_IDLE,
    ALIGN_BRANCHED,
    ALIGN_NOT_VALID,
    ALIGN_NOT_VALID_GRANTED,
    ALIGN_NOT_VALID_CROSS,
    ALIGN_NOT_VALID_CROSS_GRANTED,
    ALIGN_VALID,
    ALIGN_VALID_GRANTED,
    ALIGN_VALID_CROSS
  } align_state_e;

endpackage

// ==== src.f ====
+incdir+rtl
rtl/prefetch_pkg.sv
rtl/line_fetcher.sv
rtl/instr_aligner.sv
rtl/prefetch_buffer.sv
tests/imem_model.sv
tests/tb_prefetch_buffer.sv

// ==== tests/imem_model.sv ====
////////////////////////////////////////
// instruction memory model with random grant and read latency
// contents are a seeded random mix of 16 and 32 bit instructions
////////////////////////////////////////

module imem_model import prefetch_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     req_i,
  input  mem_req_t addr_i,
  output logic     gnt_o,
  output logic     rvalid_o,
  output line_t    rdata_o
);

  // 8 KB of halfwords, addresses wrap around
  logic [15:0] mem [4096];

  integer      seed;
  logic [31:0] r;
  logic [15:0] half;
  logic        acc_q;
  mem_req_t    acc_addr_q;
  logic        pend;
  mem_req_t    pend_addr;
  logic [1:0]  wait_cnt;

  function automatic line_t read_line(mem_req_t a);
    line_t       l;
    logic [11:0] idx;
    idx = {a.line[8:0], 3'b000};
    for (int w = 0; w < 4; w++)
      l[w] = {mem[idx + 12'(2 * w + 1)], mem[idx + 12'(2 * w)]};
    return l;
  endfunction

  // request accepted in the cycle that just ended
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc_q <= 1'b0;
    end else begin
      acc_q      <= req_i & gnt_o;
      acc_addr_q <= addr_i;
    end
  end

  initial begin
    seed = 32'hc79e;
    for (int i = 0; i < 4096; i++) begin
      r    = $random(seed);
      half = r[15:0] ^ i[15:0];
      // roughly half of all halfwords start a 32 bit instruction
      half[1:0] = r[16] ? 2'b11 : {1'b0, r[17]};
      mem[i]    = half;
    end
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
    pend     = 1'b0;
    wait_cnt = '0;

    forever begin
      @(negedge clk);
      rvalid_o = 1'b0;
      r        = $random(seed);
      if (acc_q) begin
        pend      = 1'b1;
        pend_addr = acc_addr_q;
        wait_cnt  = r[3:2];
      end
      // data comes back one to four cycles after the grant
      if (pend) begin
        if (wait_cnt == 2'd0) begin
          rvalid_o = 1'b1;
          rdata_o  = read_line(pend_addr);
          pend     = 1'b0;
        end else begin
          wait_cnt = wait_cnt - 2'd1;
        end
      end
      gnt_o = r[1:0] != 2'b00;
    end
  end

endmodule

// ==== tests/tb_prefetch_buffer.sv ====
////////////////////////////////////////
// testbench for the prefetch buffer
// streams, stalls and branches against a random instruction memory
////////////////////////////////////////

`include "prefetch_params.svh"

module tb_prefetch_buffer import prefetch_pkg::*;;

  logic       clk;
  logic       rst_n;
  logic       branch;
  addr_t      branch_addr;
  logic       ready;
  logic       valid;
  instr_out_t instr;
  logic       busy;
  logic       instr_req;
  mem_req_t   instr_addr;
  logic       instr_gnt;
  logic       instr_rvalid;
  line_t      instr_rdata;

  integer     seed;
  addr_t      exp_addr;
  int         n_xfer;
  int         n_acc;
  int         n_cross;
  logic       started;
  logic       held_ok;
  instr_out_t held;
  logic       br_pending;
  addr_t      br_line;

  prefetch_buffer prefetch_buffer_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .branch_i       (branch),
    .branch_addr_i  (branch_addr),
    .ready_i        (ready),
    .valid_o        (valid),
    .instr_o        (instr),
    .busy_o         (busy),
    .instr_req_o    (instr_req),
    .instr_addr_o   (instr_addr),
    .instr_gnt_i    (instr_gnt),
    .instr_rvalid_i (instr_rvalid),
    .instr_rdata_i  (instr_rdata)
  );

  imem_model imem_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_i    (instr_req),
    .addr_i   (instr_addr),
    .gnt_o    (instr_gnt),
    .rvalid_o (instr_rvalid),
    .rdata_o  (instr_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////
  // reference and compare
  ////////////////////////////////////////

  // little endian halfwords, the first one decides the length
  function automatic instr_out_t ref_instr(addr_t a);
    logic [11:0] idx;
    logic [15:0] lo;
    logic [15:0] hi;
    idx = a[12:1];
    lo  = imem_i.mem[idx];
    hi  = imem_i.mem[idx + 12'd1];
    return '{instr: {hi, lo}, addr: a};
  endfunction

  task automatic stop_fail(string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic check_addr(string name, addr_t want, addr_t got);
    if (got !== want)
      stop_fail($sformatf("** Error %s: expected %h, actual %h", name, want, got));
  endtask

  // upper half of a compressed instruction is don't care
  task automatic check_instr(string name, instr_out_t want, instr_out_t got);
    logic bad;
    if (want.instr[1:0] == 2'b11)
      bad = got !== want;
    else
      bad = (got.addr !== want.addr) || (got.instr[15:0] !== want.instr[15:0]);
    if (bad)
      stop_fail($sformatf("** Error %s: expected %h, actual %h", name, want, got));
  endtask

  always @(posedge clk) begin
    instr_out_t want;
    if (rst_n) begin
      if (branch) begin
        br_line    = {branch_addr[`PF_ADDR_W-1:`PF_LINE_OFS_W], {`PF_LINE_OFS_W{1'b0}}};
        br_pending = 1'b1;
      end
      // first granted request after a branch goes to the target line
      if (instr_req && instr_gnt) begin
        n_acc++;
        if (br_pending)
          check_addr("branch request", br_line, addr_t'(instr_addr));
        br_pending = 1'b0;
      end
      if (branch) begin
        started = 1'b1;
        held_ok = 1'b0;
        exp_addr = branch_addr;
        if (valid)
          stop_fail("valid_o was high in a branch cycle");
      end else begin
        if (!started && (valid || instr_req || busy))
          stop_fail("DUT became active before the first branch");
        if (held_ok) begin
          if (!valid)
            stop_fail("valid_o dropped while the core stalled");
          check_instr("stall hold", held, instr);
        end
        held_ok = 1'b0;
        if (valid && ready) begin
          want = ref_instr(exp_addr);
          check_addr("transfer addr", exp_addr, instr.addr);
          check_instr("transfer instr", want, instr);
          if (exp_addr[3:1] == 3'b111 && want.instr[1:0] == 2'b11)
            n_cross++;
          exp_addr = exp_addr + (want.instr[1:0] == 2'b11 ? addr_t'(4) : addr_t'(2));
          n_xfer++;
        end else if (valid) begin
          held    = instr;
          held_ok = 1'b1;
        end
      end
    end
  end

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  function automatic logic [31:0] next_random();
    return $random(seed);
  endfunction

  function automatic addr_t random_target();
    logic [31:0] r;
    r = next_random();
    return addr_t'({r[12:1], 1'b0});
  endfunction

  // offset 14 of a line whose last halfword starts a 32 bit instruction
  function automatic addr_t cross_target();
    logic [31:0] r;
    for (int i = 0; i < 1000; i++) begin
      r = next_random();
      if (imem_i.mem[{r[8:0], 3'b111}][1:0] == 2'b11)
        return addr_t'({r[8:0], 4'b1110});
    end
    return addr_t'(14);
  endfunction

  task automatic do_branch(addr_t target);
    @(negedge clk);
    branch      = 1'b1;
    branch_addr = target;
    @(negedge clk);
    branch = 1'b0;
  endtask

  task automatic wait_xfers(int n, logic rnd_ready);
    logic [31:0] r;
    int          target;
    int          cycles;
    target = n_xfer + n;
    cycles = 0;
    while (n_xfer < target) begin
      @(negedge clk);
      r = next_random();
      ready = rnd_ready ? r[1:0] != 2'b00 : 1'b1;
      cycles++;
      if (cycles > 200 + 50 * n)
        stop_fail("timed out waiting for instruction transfers");
    end
  endtask

  // returns right after a memory request was granted
  task automatic wait_accept();
    logic [31:0] r;
    int          target;
    int          cycles;
    target = n_acc + 1;
    cycles = 0;
    while (n_acc < target) begin
      @(negedge clk);
      r     = next_random();
      ready = r[0];
      cycles++;
      if (cycles > 500)
        stop_fail("timed out waiting for a granted memory request");
    end
  endtask

  initial begin
    logic [31:0] r;
    seed        = 32'hc79e;
    rst_n       = 1'b0;
    branch      = 1'b0;
    branch_addr = '0;
    ready       = 1'b1;
    exp_addr    = '0;
    n_xfer      = 0;
    n_acc       = 0;
    n_cross     = 0;
    started     = 1'b0;
    held_ok     = 1'b0;
    br_pending  = 1'b0;
    br_line     = '0;
    repeat (4) @(negedge clk);
    rst_n = 1'b1;
    // idle stretch before anything is asked for
    repeat (3) @(negedge clk);

    // straight stream from a line aligned target
    do_branch(32'h100);
    while (exp_addr < 32'h100 + (20 << `PF_LINE_OFS_W))
      wait_xfers(1, 1'b0);

    // crossword starts
    repeat (12) begin
      r = next_random();
      do_branch(cross_target());
      wait_xfers(4, r[0]);
    end

    // long stream under back-pressure
    do_branch(32'h800);
    while (exp_addr < 32'h800 + (16 << `PF_LINE_OFS_W))
      wait_xfers(1, 1'b1);

    // branches mid stream, some while a line read is outstanding
    repeat (60) begin
      r = next_random();
      wait_xfers(int'(r[3:0]), 1'b1);
      if (r[4])
        wait_accept();
      do_branch(random_target());
    end
    wait_xfers(8, 1'b0);

    if (n_cross == 0)
      stop_fail("no crossword instruction was transferred");
    else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule
